// File: build.f
+incdir+include
src/queue_states_pkg.sv
src/reg_port_ifc.sv
src/axil_reg_slave.sv
src/queue_occupancy_table.sv
src/queue_tail_table.sv
src/queue_states_top.sv
dv/queue_states_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the queue state testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module queue_states_tb \
    -Mdir "$BUILD_DIR" -o queue_states_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/queue_states_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dv/queue_states_tb.sv
/* Queue state block testbench
   Drives both AXI4-Lite ports and the dequeue input against a reference model */

`default_nettype none

`include "queue_states_settings.svh"

module queue_states_tb;

    // Roughly four times the length of all tests together
    localparam int MAX_CYCLES = 20000;
    localparam int NQ         = `QS_NUM_QUEUES;

    logic                         core_clk_ifc;
    logic                         rst_n;
    logic                         occ_awvalid, occ_awready, occ_wvalid, occ_wready;
    logic                         occ_bvalid, occ_bready, occ_arvalid, occ_arready;
    logic                         occ_rvalid, occ_rready;
    logic [`QS_QUEUE_IDX_W-1:0]   occ_awaddr, occ_araddr;
    logic [`QS_OCC_W-1:0]         occ_wdata, occ_rdata;
    logic                         tail_awvalid, tail_awready, tail_wvalid, tail_wready;
    logic                         tail_bvalid, tail_bready, tail_arvalid, tail_arready;
    logic                         tail_rvalid, tail_rready;
    logic [`QS_QUEUE_IDX_W-1:0]   tail_awaddr, tail_araddr;
    logic [`QS_TAIL_DATA_W-1:0]   tail_wdata, tail_rdata;
    logic                         dq_valid;
    logic [`QS_QUEUE_IDX_W-1:0]   dq_queue;
    logic [`QS_DQ_BLEN_W-1:0]     dq_blen;
    logic [`QS_NUM_QUEUES-1:0]    queue_empty;

    // Reference model, one entry per queue
    int   m_occ   [NQ];
    int   m_tail  [NQ];
    int   m_page  [NQ];
    logic m_valid [NQ];

    int seed;
    int checks;
    int errors;
    int test_errors;
    int cycle_count = 0;

    queue_states_top dut (
        .clk ( core_clk_ifc ),
        .*
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #50 core_clk_ifc = ~core_clk_ifc;
    end

    always @(posedge core_clk_ifc) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // Model helpers

    function automatic int rand_between(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic logic [`QS_NUM_QUEUES-1:0] model_empty();
        logic [`QS_NUM_QUEUES-1:0] e;
        for (int i = 0; i < NQ; i++) begin
            e[i] = (m_occ[i] == 0);
        end
        return e;
    endfunction

    // page_valid, page_ptr, tail_ptr from the top bit down
    function automatic logic [`QS_TAIL_DATA_W-1:0] expected_tail(input int q);
        return {m_valid[q], m_page[q][`QS_PAGE_PTR_W-1:0], m_tail[q][`QS_TAIL_PTR_W-1:0]};
    endfunction

    // A queue that drains loses its tail state
    function automatic void apply_dequeue(input int q, input int bytes);
        m_occ[q] = m_occ[q] - bytes;
        if (m_occ[q] == 0) begin
            m_tail[q]  = 0;
            m_page[q]  = 0;
            m_valid[q] = 1'b0;
        end
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    //////////////////////////////
    // Bus and dequeue drivers

    // A nonzero dq_bytes pulses a dequeue in the write's acceptance cycle
    task automatic occ_write(input int q, input int len, input int dq_bytes);
        @(negedge core_clk_ifc);
        occ_awvalid = 1'b1;
        occ_wvalid  = 1'b1;
        occ_awaddr  = q[`QS_QUEUE_IDX_W-1:0];
        occ_wdata   = len;
        if (dq_bytes > 0) begin
            dq_valid = 1'b1;
            dq_queue = q[`QS_QUEUE_IDX_W-1:0];
            dq_blen  = dq_bytes[`QS_DQ_BLEN_W-1:0];
        end
        @(posedge core_clk_ifc);
        check_val(32'({occ_awready, occ_wready}), 32'h3, "occupancy write handshake");
        @(negedge core_clk_ifc);
        dq_valid = 1'b0;
        check_val(32'(occ_bvalid), 32'd1, "occupancy bvalid one cycle after write");
        while (!occ_bvalid) @(negedge core_clk_ifc);
        occ_awvalid = 1'b0;
        occ_wvalid  = 1'b0;
        m_occ[q] = m_occ[q] + len;
        if (dq_bytes > 0) begin
            apply_dequeue(q, dq_bytes);
        end
        check_val(32'(queue_empty), 32'(model_empty()), $sformatf("empty after write q%0d", q));
        repeat (rand_between(0, 3)) @(negedge core_clk_ifc);
        // Response holds and nothing new is accepted meanwhile
        check_val(32'({occ_bvalid, occ_arready}), 32'h2, "occupancy write response held");
        occ_bready = 1'b1;
        @(negedge core_clk_ifc);
        occ_bready = 1'b0;
        check_val(32'(occ_bvalid), 32'd0, "occupancy bvalid after bready");
    endtask

    task automatic occ_read(input int q);
        @(negedge core_clk_ifc);
        occ_arvalid = 1'b1;
        occ_araddr  = q[`QS_QUEUE_IDX_W-1:0];
        @(posedge core_clk_ifc);
        check_val(32'(occ_arready), 32'd1, "occupancy read handshake");
        @(negedge core_clk_ifc);
        check_val(32'(occ_rvalid), 32'd1, "occupancy rvalid one cycle after read");
        while (!occ_rvalid) @(negedge core_clk_ifc);
        occ_arvalid = 1'b0;
        repeat (rand_between(0, 3)) @(negedge core_clk_ifc);
        check_val(32'({occ_rvalid, occ_arready}), 32'h2, "occupancy read response held");
        check_val(occ_rdata, m_occ[q], $sformatf("occupancy q%0d", q));
        occ_rready = 1'b1;
        @(negedge core_clk_ifc);
        occ_rready = 1'b0;
        check_val(32'(occ_rvalid), 32'd0, "occupancy rvalid after rready");
    endtask

    task automatic tail_write(input int q, input int off, input int page, input logic malloc);
        @(negedge core_clk_ifc);
        tail_awvalid = 1'b1;
        tail_wvalid  = 1'b1;
        tail_awaddr  = q[`QS_QUEUE_IDX_W-1:0];
        tail_wdata   = {malloc, page[`QS_PAGE_PTR_W-1:0], off[`QS_TAIL_PTR_W-1:0]};
        @(posedge core_clk_ifc);
        check_val(32'({tail_awready, tail_wready}), 32'h3, "tail write handshake");
        @(negedge core_clk_ifc);
        check_val(32'(tail_bvalid), 32'd1, "tail bvalid one cycle after write");
        while (!tail_bvalid) @(negedge core_clk_ifc);
        tail_awvalid = 1'b0;
        tail_wvalid  = 1'b0;
        m_tail[q] = off;
        if (malloc) begin
            m_page[q]  = page;
            m_valid[q] = 1'b1;
        end
        repeat (rand_between(0, 3)) @(negedge core_clk_ifc);
        check_val(32'({tail_bvalid, tail_arready}), 32'h2, "tail write response held");
        tail_bready = 1'b1;
        @(negedge core_clk_ifc);
        tail_bready = 1'b0;
        check_val(32'(tail_bvalid), 32'd0, "tail bvalid after bready");
    endtask

    task automatic tail_read(input int q);
        @(negedge core_clk_ifc);
        tail_arvalid = 1'b1;
        tail_araddr  = q[`QS_QUEUE_IDX_W-1:0];
        @(posedge core_clk_ifc);
        check_val(32'(tail_arready), 32'd1, "tail read handshake");
        @(negedge core_clk_ifc);
        check_val(32'(tail_rvalid), 32'd1, "tail rvalid one cycle after read");
        while (!tail_rvalid) @(negedge core_clk_ifc);
        tail_arvalid = 1'b0;
        repeat (rand_between(0, 3)) @(negedge core_clk_ifc);
        check_val(32'({tail_rvalid, tail_arready}), 32'h2, "tail read response held");
        check_val(32'(tail_rdata), 32'(expected_tail(q)), $sformatf("tail q%0d", q));
        tail_rready = 1'b1;
        @(negedge core_clk_ifc);
        tail_rready = 1'b0;
        check_val(32'(tail_rvalid), 32'd0, "tail rvalid after rready");
    endtask

    task automatic dequeue(input int q, input int bytes);
        @(negedge core_clk_ifc);
        dq_valid = 1'b1;
        dq_queue = q[`QS_QUEUE_IDX_W-1:0];
        dq_blen  = bytes[`QS_DQ_BLEN_W-1:0];
        @(negedge core_clk_ifc);
        dq_valid = 1'b0;
        apply_dequeue(q, bytes);
        check_val(32'(queue_empty), 32'(model_empty()), $sformatf("empty after dequeue q%0d", q));
    endtask

    //////////////////////////////
    // Test sequence

    initial begin
        int sel_q;
        seed        = 65;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        rst_n        = 1'b0;
        occ_awvalid  = 1'b0;
        occ_awaddr   = '0;
        occ_wvalid   = 1'b0;
        occ_wdata    = '0;
        occ_bready   = 1'b0;
        occ_arvalid  = 1'b0;
        occ_araddr   = '0;
        occ_rready   = 1'b0;
        tail_awvalid = 1'b0;
        tail_awaddr  = '0;
        tail_wvalid  = 1'b0;
        tail_wdata   = '0;
        tail_bready  = 1'b0;
        tail_arvalid = 1'b0;
        tail_araddr  = '0;
        tail_rready  = 1'b0;
        dq_valid     = 1'b0;
        dq_queue     = '0;
        dq_blen      = '0;
        for (int i = 0; i < NQ; i++) begin
            m_occ[i]   = 0;
            m_tail[i]  = 0;
            m_page[i]  = 0;
            m_valid[i] = 1'b0;
        end
        repeat (16) @(negedge core_clk_ifc);
        rst_n = 1'b1;

        check_val(32'(queue_empty), 32'(model_empty()), "empty after reset");
        check_val(32'({occ_bvalid, occ_rvalid, tail_bvalid, tail_rvalid}), 32'd0,
                  "response valids after reset");
        for (int i = 0; i < NQ; i++) begin
            occ_read(i);
            tail_read(i);
        end
        report_test("reset state");

        for (int i = 0; i < 12; i++) begin
            occ_write(rand_between(0, NQ - 1), rand_between(64, 1500), 0);
        end
        for (int i = 0; i < NQ; i++) begin
            occ_read(i);
        end
        report_test("enqueue writes");

        // Granted page first, then an offset-only update
        for (int i = 0; i < 4; i++) begin
            tail_write(i, rand_between(0, 63), rand_between(0, 511), 1'b1);
            tail_read(i);
            tail_write(i, rand_between(0, 63), rand_between(0, 511), 1'b0);
            tail_read(i);
        end
        report_test("tail writes");

        // Leave a partial word at the end of queue 9
        occ_write(9, 1000, 0);
        if (m_occ[9] % 64 == 0) begin
            occ_write(9, 100, 0);
        end
        tail_write(9, 17, 300, 1'b1);
        while (m_occ[9] > 64) begin
            dequeue(9, 64);
            occ_read(9);
        end
        dequeue(9, m_occ[9]);
        tail_read(9);
        for (int i = 0; i < NQ; i++) begin
            occ_read(i);
        end
        report_test("drain queue");

        occ_write(3, 200, 64);
        occ_read(3);
        for (int i = 0; i < 1000; i++) begin
            sel_q = rand_between(0, NQ - 1);
            case (rand_between(0, 5))
                0: occ_write(sel_q, rand_between(64, 1500), 0);
                1: occ_read(sel_q);
                2: tail_write(sel_q, rand_between(0, 63), rand_between(0, 511),
                              rand_between(0, 1) == 1);
                3: tail_read(sel_q);
                4: if (m_occ[sel_q] > 0) begin
                    dequeue(sel_q, (m_occ[sel_q] < 64) ? m_occ[sel_q] : 64);
                end
                default: occ_write(sel_q, rand_between(64, 1500), 64);
            endcase
        end
        report_test("random mix");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/queue_states_top.sv
/* Egress queue state block
   Occupancy and tail-pointer AXI4-Lite ports plus the dequeue notification */

`default_nettype none

`include "queue_states_settings.svh"

module queue_states_top (
    input  wire                          clk,
    input  wire                          rst_n,

    // Occupancy port
    input  wire                          occ_awvalid,
    output logic                         occ_awready,
    input  wire [`QS_QUEUE_IDX_W-1:0]    occ_awaddr,
    input  wire                          occ_wvalid,
    output logic                         occ_wready,
    input  wire [`QS_OCC_W-1:0]          occ_wdata,
    output logic                         occ_bvalid,
    input  wire                          occ_bready,
    input  wire                          occ_arvalid,
    output logic                         occ_arready,
    input  wire [`QS_QUEUE_IDX_W-1:0]    occ_araddr,
    output logic                         occ_rvalid,
    input  wire                          occ_rready,
    output logic [`QS_OCC_W-1:0]         occ_rdata,

    // Tail-pointer port
    input  wire                          tail_awvalid,
    output logic                         tail_awready,
    input  wire [`QS_QUEUE_IDX_W-1:0]    tail_awaddr,
    input  wire                          tail_wvalid,
    output logic                         tail_wready,
    input  wire [`QS_TAIL_DATA_W-1:0]    tail_wdata,
    output logic                         tail_bvalid,
    input  wire                          tail_bready,
    input  wire                          tail_arvalid,
    output logic                         tail_arready,
    input  wire [`QS_QUEUE_IDX_W-1:0]    tail_araddr,
    output logic                         tail_rvalid,
    input  wire                          tail_rready,
    output logic [`QS_TAIL_DATA_W-1:0]   tail_rdata,

    // Dequeue notification
    input  wire                          dq_valid,
    input  wire [`QS_QUEUE_IDX_W-1:0]    dq_queue,
    input  wire [`QS_DQ_BLEN_W-1:0]      dq_blen,

    output logic [`QS_NUM_QUEUES-1:0]    queue_empty
);

    logic                         queue_clear;
    logic [`QS_QUEUE_IDX_W-1:0]   clear_queue;

    reg_port_ifc #(.DATA_W(`QS_OCC_W))       occ_reg  ();
    reg_port_ifc #(.DATA_W(`QS_TAIL_DATA_W)) tail_reg ();

    //////////////////////////////
    // Bus adapters

    axil_reg_slave #(
        .DATA_W ( `QS_OCC_W )
    ) occ_slave (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .awvalid  ( occ_awvalid  ),
        .awready  ( occ_awready  ),
        .awaddr   ( occ_awaddr   ),
        .wvalid   ( occ_wvalid   ),
        .wready   ( occ_wready   ),
        .wdata    ( occ_wdata    ),
        .bvalid   ( occ_bvalid   ),
        .bready   ( occ_bready   ),
        .arvalid  ( occ_arvalid  ),
        .arready  ( occ_arready  ),
        .araddr   ( occ_araddr   ),
        .rvalid   ( occ_rvalid   ),
        .rready   ( occ_rready   ),
        .rdata    ( occ_rdata    ),
        .reg_port ( occ_reg      )
    );

    axil_reg_slave #(
        .DATA_W ( `QS_TAIL_DATA_W )
    ) tail_slave (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .awvalid  ( tail_awvalid ),
        .awready  ( tail_awready ),
        .awaddr   ( tail_awaddr  ),
        .wvalid   ( tail_wvalid  ),
        .wready   ( tail_wready  ),
        .wdata    ( tail_wdata   ),
        .bvalid   ( tail_bvalid  ),
        .bready   ( tail_bready  ),
        .arvalid  ( tail_arvalid ),
        .arready  ( tail_arready ),
        .araddr   ( tail_araddr  ),
        .rvalid   ( tail_rvalid  ),
        .rready   ( tail_rready  ),
        .rdata    ( tail_rdata   ),
        .reg_port ( tail_reg     )
    );

    //////////////////////////////
    // State tables

    queue_occupancy_table occ_table (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .dq_valid    ( dq_valid    ),
        .dq_queue    ( dq_queue    ),
        .dq_blen     ( dq_blen     ),
        .reg_port    ( occ_reg     ),
        .queue_empty ( queue_empty ),
        .queue_clear ( queue_clear ),
        .clear_queue ( clear_queue )
    );

    queue_tail_table tail_table (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .queue_clear ( queue_clear ),
        .clear_queue ( clear_queue ),
        .reg_port    ( tail_reg    )
    );

endmodule

`default_nettype wire

// File: src/queue_tail_table.sv
/* Queue tail table
   Tail offset and current page per queue, cleared when the queue drains */

`default_nettype none

`include "queue_states_settings.svh"

module queue_tail_table (
    input  wire                          clk,
    input  wire                          rst_n,

    // From the occupancy table
    input  wire                          queue_clear,
    input  wire [`QS_QUEUE_IDX_W-1:0]    clear_queue,

    reg_port_ifc.target                  reg_port
);

    queue_states_pkg::tail_rd_t tail_rec [`QS_NUM_QUEUES];

    queue_states_pkg::tail_wr_t wr_word;
    queue_states_pkg::tail_rd_t cur_rec;
    queue_states_pkg::tail_rd_t new_rec;
    logic                       wr_en;

    //////////////////////////////
    // Write decode

    assign wr_en   = reg_port.req_valid &&
                     (reg_port.req_op == queue_states_pkg::REG_WRITE);
    assign wr_word = reg_port.req_wdata;
    assign cur_rec = tail_rec[reg_port.req_queue];

    // Offset always moves, the page only on a granted malloc
    always_comb begin
        new_rec          = cur_rec;
        new_rec.tail_ptr = wr_word.new_tail_ptr;
        if (wr_word.malloc_approved) begin
            new_rec.page_ptr   = wr_word.next_page_ptr;
            new_rec.page_valid = 1'b1;
        end
    end

    //////////////////////////////
    // Records

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
                tail_rec[q] <= '0;
            end
        end else begin
            if (wr_en) begin
                tail_rec[reg_port.req_queue] <= new_rec;
            end
            // Drain wins over a write to the same queue
            if (queue_clear) begin
                tail_rec[clear_queue] <= '0;
            end
        end
    end

    assign reg_port.rdata = cur_rec;

endmodule

`default_nettype wire

// File: src/queue_occupancy_table.sv
/* Queue occupancy table
   Byte counters and empty flags per queue, fed by enqueue writes and dequeues */

`default_nettype none

`include "queue_states_settings.svh"

module queue_occupancy_table (
    input  wire                          clk,
    input  wire                          rst_n,

    // Dequeue notification, one word per pulse
    input  wire                          dq_valid,
    input  wire [`QS_QUEUE_IDX_W-1:0]    dq_queue,
    input  wire [`QS_DQ_BLEN_W-1:0]      dq_blen,

    reg_port_ifc.target                  reg_port,

    output logic [`QS_NUM_QUEUES-1:0]    queue_empty,

    // Drain notice for the tail table
    output logic                         queue_clear,
    output logic [`QS_QUEUE_IDX_W-1:0]   clear_queue
);

    logic [`QS_OCC_W-1:0] occ      [`QS_NUM_QUEUES];
    logic [`QS_OCC_W-1:0] next_occ [`QS_NUM_QUEUES];

    logic                 enq_valid;
    logic [`QS_OCC_W-1:0] dq_blen_ext;

    //////////////////////////////
    // Next occupancy

    assign enq_valid = reg_port.req_valid &&
                       (reg_port.req_op == queue_states_pkg::REG_WRITE);

    assign dq_blen_ext = {{(`QS_OCC_W - `QS_DQ_BLEN_W){1'b0}}, dq_blen};

    // Enqueue and dequeue on the same queue both land this cycle
    always_comb begin
        for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
            next_occ[q] = occ[q];
            if (enq_valid && (reg_port.req_queue == q[`QS_QUEUE_IDX_W-1:0])) begin
                next_occ[q] = next_occ[q] + reg_port.req_wdata;
            end
            if (dq_valid && (dq_queue == q[`QS_QUEUE_IDX_W-1:0])) begin
                next_occ[q] = next_occ[q] - dq_blen_ext;
            end
        end
    end

    //////////////////////////////
    // Counters and empty flags

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
                occ[q]         <= '0;
                queue_empty[q] <= 1'b1;
            end
        end else begin
            for (int q = 0; q < `QS_NUM_QUEUES; q++) begin
                occ[q]         <= next_occ[q];
                queue_empty[q] <= (next_occ[q] == '0);
            end
        end
    end

    // A dequeue that empties its queue also drops the tail state
    assign queue_clear = dq_valid && (next_occ[dq_queue] == '0);
    assign clear_queue = dq_queue;

    // Reads see the value before this cycle's updates
    assign reg_port.rdata = occ[reg_port.req_queue];

endmodule

`default_nettype wire

// File: src/axil_reg_slave.sv
/* AXI4-Lite slave adapter
   Turns bus transactions into single-cycle register requests */

`default_nettype none

`include "queue_states_settings.svh"

module axil_reg_slave #(
    parameter int DATA_W = 32
) (
    input  wire                        clk,
    input  wire                        rst_n,

    // Write address and data
    input  wire                        awvalid,
    output logic                       awready,
    input  wire [`QS_QUEUE_IDX_W-1:0]  awaddr,
    input  wire                        wvalid,
    output logic                       wready,
    input  wire [DATA_W-1:0]           wdata,

    // Write response
    output logic                       bvalid,
    input  wire                        bready,

    // Read address and data
    input  wire                        arvalid,
    output logic                       arready,
    input  wire [`QS_QUEUE_IDX_W-1:0]  araddr,
    output logic                       rvalid,
    input  wire                        rready,
    output logic [DATA_W-1:0]          rdata,

    reg_port_ifc.master                reg_port
);

    queue_states_pkg::axil_state_e state;

    logic in_idle;
    logic wr_accept;
    logic rd_accept;

    //////////////////////////////
    // Handshakes

    assign in_idle = (state == queue_states_pkg::IDLE);

    // Address and data must arrive together
    assign awready   = in_idle && awvalid && wvalid;
    assign wready    = awready;
    assign wr_accept = awready;

    // Reads only go through when no write is on offer
    assign arready   = in_idle && !awvalid && !wvalid;
    assign rd_accept = arready && arvalid;

    assign bvalid = (state == queue_states_pkg::WRITE_RESP);
    assign rvalid = (state == queue_states_pkg::READ_RESP);

    //////////////////////////////
    // Register request

    assign reg_port.req_valid = wr_accept || rd_accept;
    assign reg_port.req_op    = wr_accept ? queue_states_pkg::REG_WRITE
                                          : queue_states_pkg::REG_READ;
    assign reg_port.req_queue = wr_accept ? awaddr : araddr;
    assign reg_port.req_wdata = wdata;

    //////////////////////////////
    // Response FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= queue_states_pkg::IDLE;
        end else begin
            case (state)
                queue_states_pkg::IDLE: begin
                    if (wr_accept) begin
                        state <= queue_states_pkg::WRITE_RESP;
                    end else if (rd_accept) begin
                        state <= queue_states_pkg::READ_RESP;
                    end
                end
                queue_states_pkg::WRITE_RESP: begin
                    if (bready) begin
                        state <= queue_states_pkg::IDLE;
                    end
                end
                queue_states_pkg::READ_RESP: begin
                    if (rready) begin
                        state <= queue_states_pkg::IDLE;
                    end
                end
                default: begin
                    state <= queue_states_pkg::IDLE;
                end
            endcase
        end
    end

    // Held until the master takes it
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= reg_port.rdata;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_port_ifc.sv
/* Register request port
   One single-cycle request per transfer, read data returned combinationally */

`default_nettype none

`include "queue_states_settings.svh"

interface reg_port_ifc #(
    parameter int DATA_W = 32
);

    logic                        req_valid;
    queue_states_pkg::reg_op_e   req_op;
    logic [`QS_QUEUE_IDX_W-1:0]  req_queue;
    logic [DATA_W-1:0]           req_wdata;
    logic [DATA_W-1:0]           rdata;

    // Bus adapter side
    modport master (
        output req_valid, req_op, req_queue, req_wdata,
        input  rdata
    );

    // State table side
    modport target (
        input  req_valid, req_op, req_queue, req_wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: src/queue_states_pkg.sv
/* Queue state types
   Register opcodes, bus adapter states and tail-pointer word layouts */

`default_nettype none

`include "queue_states_settings.svh"

package queue_states_pkg;

    //////////////////////////////
    // Control encodings

    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WRITE_RESP = 2'd1,
        READ_RESP  = 2'd2
    } axil_state_e;

    //////////////////////////////
    // Tail-pointer port words

    // Read side, what the queue currently owns
    typedef struct packed {
        logic                      page_valid;
        logic [`QS_PAGE_PTR_W-1:0] page_ptr;
        logic [`QS_TAIL_PTR_W-1:0] tail_ptr;
    } tail_rd_t;

    // Write side, from the congestion manager
    typedef struct packed {
        logic                      malloc_approved;
        logic [`QS_PAGE_PTR_W-1:0] next_page_ptr;
        logic [`QS_TAIL_PTR_W-1:0] new_tail_ptr;
    } tail_wr_t;

endpackage

`default_nettype wire

// File: include/queue_states_settings.svh
/* Queue state block configuration
   Queue counts, field widths and page geometry */

`ifndef QUEUE_STATES_SETTINGS_SVH
`define QUEUE_STATES_SETTINGS_SVH

// Queue layout
`define QS_NUM_EGR_PORTS    4
`define QS_QUEUES_PER_PORT  4
`define QS_NUM_QUEUES       (`QS_NUM_EGR_PORTS * `QS_QUEUES_PER_PORT)
`define QS_QUEUE_IDX_W      4

// Queue memory words and dequeue byte counts
`define QS_BYTES_PER_WORD   64
`define QS_DQ_BLEN_W        7

// Page geometry
`define QS_WORDS_PER_PAGE   64
`define QS_TAIL_PTR_W       6
`define QS_NUM_PAGES        512
`define QS_PAGE_PTR_W       9

// Register port data widths
`define QS_OCC_W            32
`define QS_TAIL_DATA_W      16

`endif
